// ==== rtl/pet_pkg.sv ====
package pet_pkg;

    // width of the pet state code driven by the game logic
    localparam int PET_STATE_W = 4;

    // pet moods as reported by the game
    // codes 6 to 15 are not assigned
    typedef enum logic [PET_STATE_W-1:0] {
        sleeping = 4'd0,
        idle     = 4'd1,
        hungry   = 4'd2,
        sick     = 4'd3,
        playful  = 4'd4,
        happy    = 4'd5
    } pet_state_e;

endpackage

// ==== rtl/buzz_pkg.sv ====
package buzz_pkg;

    // base beep length, scaled down for simulation
    localparam int UNIT_CYCLES = 16;

    // dead time after an accepted clap
    localparam int HOLDOFF_CYCLES = 40;

    // request fields
    localparam int BEEPS_W = 3;
    localparam int SPEED_W = 2;

    // alert queue
    localparam int FIFO_DEPTH = 4;

    // derived counter widths
    localparam int HOLDOFF_W = $clog2(HOLDOFF_CYCLES + 1);
    localparam int TONE_W = $clog2(UNIT_CYCLES + 1);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [BEEPS_W-1:0] beeps_t;
    typedef logic [SPEED_W-1:0] speed_t;
    typedef logic [HOLDOFF_W-1:0] holdoff_t;
    typedef logic [TONE_W-1:0] tone_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    // buzzer sequencer
    typedef enum logic [1:0] {
        seq_idle     = 2'd0,
        seq_load     = 2'd1,
        seq_tone_on  = 2'd2,
        seq_tone_off = 2'd3
    } seq_state_e;

endpackage

// ==== rtl/sound_detect.sv ====
`timescale 1ns/1ps

module sound_detect (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         mic,
    input  pet_pkg::pet_state_e          pet_state,
    input  logic                         full,
    output logic                         push,
    output logic [buzz_pkg::BEEPS_W-1:0] push_beeps,
    output logic [buzz_pkg::SPEED_W-1:0] push_speed,
    output logic                         dropped
);

    logic              mic_meta;
    logic              mic_sync;
    logic              mic_prev;
    logic              mic_rise;
    logic              accept;
    buzz_pkg::holdoff_t holdoff_cnt;
    buzz_pkg::beeps_t  rule_beeps;
    buzz_pkg::speed_t  rule_speed;

    // mic comes straight from an analog comparator
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mic_meta <= 1'b0;
            mic_sync <= 1'b0;
            mic_prev <= 1'b0;
        end else begin
            mic_meta <= mic;
            mic_sync <= mic_meta;
            mic_prev <= mic_sync;
        end
    end

    assign mic_rise = mic_sync & ~mic_prev;

    // edges inside the hold-off window are bounce or echo
    assign accept = mic_rise && (holdoff_cnt == '0);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            holdoff_cnt <= '0;
        end else if (accept) begin
            holdoff_cnt <= buzz_pkg::holdoff_t'(buzz_pkg::HOLDOFF_CYCLES);
        end else if (holdoff_cnt != '0) begin
            holdoff_cnt <= holdoff_cnt - 1'b1;
        end
    end

    // beep rule, pet mood to beep count and speed
    always_comb begin
        case (pet_state)
            pet_pkg::sleeping, pet_pkg::idle: begin
                rule_beeps = buzz_pkg::beeps_t'(3);
                rule_speed = buzz_pkg::speed_t'(2);
            end
            pet_pkg::hungry: begin
                rule_beeps = buzz_pkg::beeps_t'(1);
                rule_speed = buzz_pkg::speed_t'(1);
            end
            pet_pkg::playful: begin
                rule_beeps = buzz_pkg::beeps_t'(5);
                rule_speed = buzz_pkg::speed_t'(1);
            end
            pet_pkg::happy: begin
                rule_beeps = buzz_pkg::beeps_t'(2);
                rule_speed = buzz_pkg::speed_t'(1);
            end
            default: begin
                rule_beeps = buzz_pkg::beeps_t'(1);
                rule_speed = buzz_pkg::speed_t'(1);
            end
        endcase
    end

    // push or drop, one cycle after the edge
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            push    <= 1'b0;
            dropped <= 1'b0;
        end else begin
            push    <= accept && !full;
            dropped <= accept && full;
        end
    end

    // snapshot of the mood at the edge
    always_ff @(posedge clk) begin
        if (accept) begin
            push_beeps <= rule_beeps;
            push_speed <= rule_speed;
        end
    end

    a_push_or_drop: assert property (@(posedge clk) disable iff (!rst) !(push && dropped))
        else $error("push and dropped high together");

    // full is sampled one cycle before the push lands in the queue
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst) push |-> !full)
        else $error("push while queue full");

endmodule

// ==== rtl/alert_fifo.sv ====
`timescale 1ns/1ps

module alert_fifo (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  logic [buzz_pkg::BEEPS_W-1:0] push_beeps,
    input  logic [buzz_pkg::SPEED_W-1:0] push_speed,
    input  logic                         pop,
    output logic [buzz_pkg::BEEPS_W-1:0] pop_beeps,
    output logic [buzz_pkg::SPEED_W-1:0] pop_speed,
    output logic                         empty,
    output logic                         full
);

    buzz_pkg::beeps_t    beeps_mem [buzz_pkg::FIFO_DEPTH];
    buzz_pkg::speed_t    speed_mem [buzz_pkg::FIFO_DEPTH];
    buzz_pkg::fifo_ptr_t wr_ptr;
    buzz_pkg::fifo_ptr_t rd_ptr;
    buzz_pkg::fifo_cnt_t count;
    logic                do_push;
    logic                do_pop;

    assign empty = (count == '0);
    assign full  = (count == buzz_pkg::fifo_cnt_t'(buzz_pkg::FIFO_DEPTH));

    // qualified strobes, a bad push or pop is ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry is always on the outputs
    assign pop_beeps = beeps_mem[rd_ptr];
    assign pop_speed = speed_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            beeps_mem[wr_ptr] <= push_beeps;
            speed_mem[wr_ptr] <= push_speed;
        end
    end

    // depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // push and pop together leave the count alone
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (do_push && !do_pop) begin
            count <= count + 1'b1;
        end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst) pop |-> !empty)
        else $error("pop while queue empty");

    a_count_bound: assert property (@(posedge clk) disable iff (!rst)
        count <= buzz_pkg::fifo_cnt_t'(buzz_pkg::FIFO_DEPTH))
        else $error("queue occupancy above depth");

endmodule

// ==== rtl/buzzer_driver.sv ====
`timescale 1ns/1ps

module buzzer_driver (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         empty,
    input  logic [buzz_pkg::BEEPS_W-1:0] pop_beeps,
    input  logic [buzz_pkg::SPEED_W-1:0] pop_speed,
    output logic                         pop,
    output logic                         buzzer,
    output logic                         awake
);

    buzz_pkg::seq_state_e state;
    buzz_pkg::beeps_t     beeps_left;
    buzz_pkg::speed_t     speed_q;
    buzz_pkg::tone_t      tone_cnt;
    buzz_pkg::tone_t      tone_limit;
    logic                 tone_done;
    logic                 last_beep;

    // tone length T = UNIT_CYCLES / speed
    function automatic buzz_pkg::tone_t tone_len(input buzz_pkg::speed_t speed);
        case (speed)
            buzz_pkg::speed_t'(2): tone_len = buzz_pkg::tone_t'(buzz_pkg::UNIT_CYCLES / 2);
            buzz_pkg::speed_t'(3): tone_len = buzz_pkg::tone_t'(buzz_pkg::UNIT_CYCLES / 3);
            // speed 0 never comes out of the rule, play it slow
            default: tone_len = buzz_pkg::tone_t'(buzz_pkg::UNIT_CYCLES);
        endcase
    endfunction

    assign tone_limit = tone_len(speed_q);
    assign tone_done  = (tone_cnt == tone_limit - 1'b1);
    assign last_beep  = (beeps_left <= buzz_pkg::beeps_t'(1));

    // queue head is taken in the load cycle
    assign pop   = (state == buzz_pkg::seq_load);
    assign awake = (state != buzz_pkg::seq_idle);

    always_ff @(posedge clk) begin
        if (state == buzz_pkg::seq_load) begin
            speed_q <= pop_speed;
        end
    end

    // buzzer is registered next to the state so it switches with it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= buzz_pkg::seq_idle;
            beeps_left <= '0;
            tone_cnt   <= '0;
            buzzer     <= 1'b1;
        end else begin
            case (state)
                buzz_pkg::seq_idle: begin
                    if (!empty) begin
                        state <= buzz_pkg::seq_load;
                    end
                end
                buzz_pkg::seq_load: begin
                    beeps_left <= pop_beeps;
                    tone_cnt   <= '0;
                    buzzer     <= 1'b0;
                    state      <= buzz_pkg::seq_tone_on;
                end
                buzz_pkg::seq_tone_on: begin
                    if (tone_done) begin
                        tone_cnt <= '0;
                        buzzer   <= 1'b1;
                        state    <= buzz_pkg::seq_tone_off;
                    end else begin
                        tone_cnt <= tone_cnt + 1'b1;
                    end
                end
                buzz_pkg::seq_tone_off: begin
                    if (tone_done) begin
                        tone_cnt <= '0;
                        if (last_beep) begin
                            state <= buzz_pkg::seq_idle;
                        end else begin
                            // next beep of the same request
                            beeps_left <= beeps_left - 1'b1;
                            buzzer     <= 1'b0;
                            state      <= buzz_pkg::seq_tone_on;
                        end
                    end else begin
                        tone_cnt <= tone_cnt + 1'b1;
                    end
                end
                default: begin
                    buzzer <= 1'b1;
                    state  <= buzz_pkg::seq_idle;
                end
            endcase
        end
    end

    a_quiet_idle: assert property (@(posedge clk) disable iff (!rst)
        (state == buzz_pkg::seq_idle) |-> buzzer)
        else $error("buzzer sounding while sequencer idle");

endmodule

// ==== rtl/pet_alarm_top.sv ====
`timescale 1ns/1ps

module pet_alarm_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                mic,
    input  pet_pkg::pet_state_e pet_state,
    output logic                buzzer,
    output logic                awake,
    output logic                dropped
);

    // producer to queue
    logic                         push;
    logic [buzz_pkg::BEEPS_W-1:0] push_beeps;
    logic [buzz_pkg::SPEED_W-1:0] push_speed;
    logic                         full;

    // queue to consumer
    logic                         pop;
    logic [buzz_pkg::BEEPS_W-1:0] pop_beeps;
    logic [buzz_pkg::SPEED_W-1:0] pop_speed;
    logic                         empty;

    sound_detect sound_detect_i (
        .clk        (clk),
        .rst        (rst),
        .mic        (mic),
        .pet_state  (pet_state),
        .full       (full),
        .push       (push),
        .push_beeps (push_beeps),
        .push_speed (push_speed),
        .dropped    (dropped)
    );

    alert_fifo alert_fifo_i (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_beeps (push_beeps),
        .push_speed (push_speed),
        .pop        (pop),
        .pop_beeps  (pop_beeps),
        .pop_speed  (pop_speed),
        .empty      (empty),
        .full       (full)
    );

    buzzer_driver buzzer_driver_i (
        .clk       (clk),
        .rst       (rst),
        .empty     (empty),
        .pop_beeps (pop_beeps),
        .pop_speed (pop_speed),
        .pop       (pop),
        .buzzer    (buzzer),
        .awake     (awake)
    );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset released on a rising edge, like the rest of the stimulus
    initial begin
        rst <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            mic,
    input  logic [pet_pkg::PET_STATE_W-1:0] pet_state,
    input  logic                            buzzer,
    input  logic                            awake,
    input  logic                            dropped,
    input  logic                            drain,
    input  int                              exp_accepts,
    output int                              errors,
    output logic                            closed
);

    // reference model of the clap front end and queue occupancy
    logic sync_a;
    logic sync_b;
    logic sync_prev;
    logic push_due;
    logic drop_due;
    logic awake_q;
    int   hold_cnt;
    int   occ;
    int   beeps_q[$];
    int   tone_q[$];

    // playback measurement
    logic in_play;
    logic first_run;
    logic run_level;
    int   run_len;
    int   low_runs;
    int   awake_len;
    int   cur_beeps;
    int   cur_tone;
    int   idle_wait;
    int   accepted;
    int   played;
    int   drop_seen;

    // pet mood to beep count and speed
    function automatic void beep_rule(input logic [3:0] code, output int beeps,
                                      output int speed);
        case (code)
            pet_pkg::sleeping, pet_pkg::idle: begin
                beeps = 3;
                speed = 2;
            end
            pet_pkg::playful: begin
                beeps = 5;
                speed = 1;
            end
            pet_pkg::happy: begin
                beeps = 2;
                speed = 1;
            end
            default: begin
                beeps = 1;
                speed = 1;
            end
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic close_run();
        if (run_level) begin
            check_value("buzzer high cycles", cur_tone, run_len);
        end else begin
            check_value("buzzer low cycles", cur_tone, run_len);
        end
    endtask

    always @(posedge clk) begin
        logic rise;
        logic accept;
        logic full_pred;
        int   beeps;
        int   speed;
        if (!rst) begin
            sync_a    = 1'b0;
            sync_b    = 1'b0;
            sync_prev = 1'b0;
            push_due  = 1'b0;
            drop_due  = 1'b0;
            awake_q   = 1'b0;
            in_play   = 1'b0;
            first_run = 1'b0;
            run_level = 1'b1;
            run_len   = 0;
            hold_cnt  = 0;
            occ       = 0;
            idle_wait = 0;
            accepted  = 0;
            played    = 0;
            drop_seen = 0;
            beeps_q.delete();
            tone_q.delete();
            closed <= 1'b0;
        end else begin
            // dropped follows an edge that met a full queue by one cycle
            check_value("dropped", int'(drop_due), int'(dropped));
            if (dropped) begin
                drop_seen++;
                if (beeps_q.size() == 0) begin
                    report_failure("dropped pulse with no outstanding clap");
                end else begin
                    void'(beeps_q.pop_back());
                    void'(tone_q.pop_back());
                end
            end

            if (awake && !awake_q) begin
                // oldest request starts playing in the load cycle
                if (beeps_q.size() == 0) begin
                    report_failure("playback started with no clap waiting");
                    cur_beeps = 0;
                    cur_tone  = 0;
                end else begin
                    cur_beeps = beeps_q.pop_front();
                    cur_tone  = tone_q.pop_front();
                end
                check_value("buzzer", 1, int'(buzzer));
                in_play   = 1'b1;
                first_run = 1'b1;
                low_runs  = 0;
                awake_len = 1;
                played++;
            end else if (awake && in_play) begin
                awake_len++;
                if (first_run || buzzer != run_level) begin
                    if (!first_run) begin
                        close_run();
                    end
                    first_run = 1'b0;
                    run_level = buzzer;
                    run_len   = 1;
                    if (!buzzer) begin
                        low_runs++;
                    end
                end else begin
                    run_len++;
                end
            end else if (!awake && in_play) begin
                close_run();
                check_value("buzzer at end of playback", 1, int'(run_level));
                check_value("beep count", cur_beeps, low_runs);
                check_value("awake cycles", 1 + 2 * cur_tone * cur_beeps, awake_len);
                in_play = 1'b0;
            end
            if (!awake) begin
                check_value("buzzer", 1, int'(buzzer));
            end

            // queue occupancy as the DUT sees it at this edge
            full_pred = (occ == buzz_pkg::FIFO_DEPTH);
            if (push_due) begin
                occ++;
            end
            if (awake && !awake_q && occ > 0) begin
                occ--;
            end
            if (!awake && occ > 0) begin
                idle_wait++;
            end else begin
                idle_wait = 0;
            end
            if (idle_wait == 3) begin
                report_failure("buzzer driver stayed idle with alerts queued");
            end

            // two-flop synchronizer, edge detect and hold-off
            rise   = sync_b && !sync_prev;
            accept = rise && (hold_cnt == 0);
            if (accept) begin
                hold_cnt = buzz_pkg::HOLDOFF_CYCLES;
                beep_rule(pet_state, beeps, speed);
                beeps_q.push_back(beeps);
                tone_q.push_back(buzz_pkg::UNIT_CYCLES / speed);
                accepted++;
            end else if (hold_cnt > 0) begin
                hold_cnt--;
            end
            push_due  = accept && !full_pred;
            drop_due  = accept && full_pred;
            sync_prev = sync_b;
            sync_b    = sync_a;
            sync_a    = mic;
            awake_q   = awake;

            if (drain && !closed && !in_play && !awake && !push_due && !drop_due
                    && occ == 0 && beeps_q.size() == 0) begin
                check_value("claps accepted", exp_accepts, accepted);
                check_value("claps played or dropped", exp_accepts, played + drop_seen);
                closed <= 1'b1;
            end
        end
    end

endmodule

// ==== test/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int N_ENTRIES = 15;

    logic                clk;
    logic                rst;
    logic                mic;
    pet_pkg::pet_state_e pet_state;
    logic                buzzer;
    logic                awake;
    logic                dropped;
    logic                drain;
    logic                closed;
    int                  errors;
    int                  exp_accepts;
    int                  cycle_count;
    int                  cycle_limit;
    int unsigned         lcg_state;

    // mood, mic pulses, high time, gap after each pulse, expected accepted claps
    logic [pet_pkg::PET_STATE_W-1:0] tab_state [N_ENTRIES];
    int tab_pulses [N_ENTRIES];
    int tab_high   [N_ENTRIES];
    int tab_gap    [N_ENTRIES];
    int tab_claps  [N_ENTRIES];

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    pet_alarm_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .mic       (mic),
        .pet_state (pet_state),
        .buzzer    (buzzer),
        .awake     (awake),
        .dropped   (dropped)
    );

    tb_checker mon_i (
        .clk         (clk),
        .rst         (rst),
        .mic         (mic),
        .pet_state   (pet_state),
        .buzzer      (buzzer),
        .awake       (awake),
        .dropped     (dropped),
        .drain       (drain),
        .exp_accepts (exp_accepts),
        .errors      (errors),
        .closed      (closed)
    );

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic set_entry(input int idx, input logic [3:0] st, input int pulses,
                             input int high, input int gap, input int claps);
        tab_state[idx]  = st;
        tab_pulses[idx] = pulses;
        tab_high[idx]   = high;
        tab_gap[idx]    = gap;
        tab_claps[idx]  = claps;
    endtask

    task automatic load_table();
        set_entry(0, pet_pkg::sleeping, 0, 0, 30, 0);
        // one clap per mood, then an unassigned code
        set_entry(1, pet_pkg::sleeping, 1, 3, 120, 1);
        set_entry(2, pet_pkg::idle, 1, 3, 120, 1);
        set_entry(3, pet_pkg::hungry, 1, 4, 120, 1);
        set_entry(4, pet_pkg::sick, 1, 3, 120, 1);
        set_entry(5, pet_pkg::playful, 1, 3, 200, 1);
        set_entry(6, pet_pkg::happy, 1, 3, 120, 1);
        set_entry(7, 4'd9, 1, 3, 120, 1);
        // bouncing clap inside the hold-off
        set_entry(8, pet_pkg::happy, 3, 2, 10, 1);
        set_entry(9, pet_pkg::sleeping, 0, 0, 150, 0);
        // claps queued behind a long playful playback
        set_entry(10, pet_pkg::playful, 1, 3, 44, 1);
        set_entry(11, pet_pkg::hungry, 1, 3, 44, 1);
        set_entry(12, pet_pkg::happy, 1, 3, 44, 1);
        set_entry(13, pet_pkg::sleeping, 1, 3, 600, 1);
        // overflow, queue fills and the last clap is dropped
        set_entry(14, pet_pkg::playful, 7, 3, 40, 7);
    endtask

    task automatic play_entry(input int idx);
        int unsigned pad;
        @(posedge clk);
        pet_state <= pet_pkg::pet_state_e'(tab_state[idx]);
        if (tab_pulses[idx] == 0) begin
            repeat (tab_gap[idx]) @(posedge clk);
        end
        // mood settles before the first clap
        repeat (4) @(posedge clk);
        for (int p = 0; p < tab_pulses[idx]; p++) begin
            lcg_state = lcg_next(lcg_state);
            pad = (lcg_state >> 16) % 4;
            @(posedge clk);
            mic <= 1'b1;
            repeat (tab_high[idx]) @(posedge clk);
            mic <= 1'b0;
            repeat (tab_gap[idx] + int'(pad)) @(posedge clk);
        end
    endtask

    initial begin
        mic       <= 1'b0;
        pet_state <= pet_pkg::sleeping;
        drain     <= 1'b0;
        lcg_state = 32'd48995;
        load_table();
        exp_accepts = 0;
        cycle_limit = 0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            exp_accepts += tab_claps[i];
            cycle_limit += 5 + tab_gap[i] + tab_pulses[i] * (tab_high[i] + tab_gap[i] + 4
                           + 2 * 5 * buzz_pkg::UNIT_CYCLES);
        end
        cycle_limit = 2 * (cycle_limit + 10);
        wait (rst === 1'b1);
        for (int i = 0; i < N_ENTRIES; i++) begin
            play_entry(i);
        end
        @(posedge clk);
        drain <= 1'b1;
        wait (closed === 1'b1);
        $display("errors: %0d over %0d expected claps", errors, exp_accepts);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, alerts never drained (%0d errors so far)",
                     cycle_count, errors);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
rtl/pet_pkg.sv
rtl/buzz_pkg.sv
rtl/sound_detect.sv
rtl/alert_fifo.sv
rtl/buzzer_driver.sv
rtl/pet_alarm_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pet alarm testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_top \
    -f sources.f \
    -o tb_top_sim

./obj_dir/tb_top_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi

echo "pass message not found in sim.log"
exit 1
